/* logic/irq_pkg.sv */
/*
 * Interrupt package
 * Line count, valid line mask, privilege levels and the interrupt id type
 */

package irq_pkg;

  // ------------------------------
  // Interrupt lines
  // ------------------------------
  parameter int unsigned NUM_IRQ = 32;

  // Lines 31..16 are platform, 11/7/3 are MEI/MTI/MSI
  parameter logic [NUM_IRQ-1:0] VALID_IRQ_MASK = 32'hffff_0888;

  // Interrupt number as reported with the acknowledge
  typedef logic [4:0] irq_id_t;

  // ------------------------------
  // Privilege
  // ------------------------------
  // Encodings follow the mstatus.MPP field
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

endpackage : irq_pkg

/* logic/sleep_pkg.sv */
/*
 * Sleep package
 * WFI/WFE encodings, writeback instruction views and pipeline status bundles
 */

package sleep_pkg;

  // Full instruction words
  parameter logic [31:0] WFI_INSTR = 32'h1050_0073;
  parameter logic [31:0] WFE_INSTR = 32'h8C00_0073;

  // SYSTEM major opcode and the funct12 values that select WFI and WFE
  parameter logic [6:0]  SYSTEM_OPCODE = 7'b111_0011;
  parameter logic [11:0] FUNCT12_WFI   = 12'h105;
  parameter logic [11:0] FUNCT12_WFE   = 12'h8C0;

  // I-type layout of a SYSTEM instruction
  typedef struct packed {
    logic [11:0] funct12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } sys_instr_t;

  // Same word, seen raw or split into fields
  typedef union packed {
    logic [31:0] raw;
    sys_instr_t  sys;
  } instr_word_u;

  typedef struct packed {
    logic        valid;
    instr_word_u instr;
    logic        bus_err;
    logic        mpu_ok;
    logic        kill;
    logic        debug_mode;
    logic        dcsr_step;
  } wb_status_t;

  // Any of these keeps the core awake
  typedef struct packed {
    logic instr_outstanding;
    logic data_outstanding;
    logic wbuf_nonempty;
  } bus_status_t;

endpackage : sleep_pkg

/* logic/irq_sampler.sv */
/*
 * Interrupt sampler
 * Registers the external lines into mip and forms the pending-and-enabled set
 */

`timescale 1ns/1ps

module irq_sampler import irq_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic [NUM_IRQ-1:0] irq_i,
  input  logic [NUM_IRQ-1:0] mie_i,
  output logic [NUM_IRQ-1:0] mip_o,
  output logic [NUM_IRQ-1:0] pending_enabled_o
);

  logic [NUM_IRQ-1:0] mip_q;

  // Reserved lines never reach mip
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mip_q <= '0;
    end else begin
      mip_q <= irq_i & VALID_IRQ_MASK;
    end
  end

  assign mip_o = mip_q;

  // Shared by arbitration and wake-up, so mie changes act at once
  assign pending_enabled_o = mip_q & mie_i;

endmodule : irq_sampler

/* logic/wb_sleep_decoder.sv */
/*
 * Writeback sleep decoder
 * Flags a valid, non-killed WFI or WFE sitting in the writeback stage
 */

`timescale 1ns/1ps

module wb_sleep_decoder import irq_pkg::*; import sleep_pkg::*; (
  input  wb_status_t wb_status_i,
  input  priv_lvl_e  priv_lvl_i,
  input  logic       mstatus_tw_i,
  output logic       wfi_wfe_in_wb_o,
  output logic       is_wfe_o
);

  sys_instr_t sys;
  logic       sys_plain;
  logic       is_wfi;
  logic       is_wfe;
  logic       instr_ok;

  assign sys = wb_status_i.instr.sys;

  // No register operands and funct3 zero
  assign sys_plain = (sys.opcode == SYSTEM_OPCODE) &&
                     (sys.funct3 == 3'b000)        &&
                     (sys.rs1 == 5'd0)             &&
                     (sys.rd == 5'd0);

  assign is_wfi = sys_plain && (sys.funct12 == FUNCT12_WFI);
  assign is_wfe = sys_plain && (sys.funct12 == FUNCT12_WFE);

  // ------------------------------
  // Conditions that invalidate
  // ------------------------------
  // U-mode with TW set traps instead of waiting
  assign instr_ok = wb_status_i.valid       &&
                    !wb_status_i.bus_err    &&
                    wb_status_i.mpu_ok      &&
                    !wb_status_i.kill       &&
                    !wb_status_i.debug_mode &&
                    !wb_status_i.dcsr_step  &&
                    !((priv_lvl_i == PRIV_LVL_U) && mstatus_tw_i);

  assign wfi_wfe_in_wb_o = instr_ok && (is_wfi || is_wfe);
  assign is_wfe_o        = instr_ok && is_wfe;

endmodule : wb_sleep_decoder

/* logic/irq_arbiter.sv */
/*
 * Interrupt arbiter
 * Fixed-priority pick over the valid lines, privilege gating,
 * and a registered single-cycle acknowledge with the winning id
 */

`timescale 1ns/1ps

module irq_arbiter import irq_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic [NUM_IRQ-1:0] pending_enabled_i,
  input  logic               mstatus_mie_i,
  input  priv_lvl_e          priv_lvl_i,
  output logic               irq_ack_o,
  output irq_id_t            irq_id_o
);

  logic    win_valid;
  irq_id_t win_id;
  logic    take;
  logic    ack_q;
  irq_id_t id_q;

  // ------------------------------
  // Priority encoder
  // ------------------------------
  // Order is 31..16, 11, 3, 7; lowest first so later hits override
  always_comb begin
    win_valid = 1'b0;
    win_id    = '0;
    if (pending_enabled_i[7]) begin
      win_valid = 1'b1;
      win_id    = irq_id_t'(7);
    end
    if (pending_enabled_i[3]) begin
      win_valid = 1'b1;
      win_id    = irq_id_t'(3);
    end
    if (pending_enabled_i[11]) begin
      win_valid = 1'b1;
      win_id    = irq_id_t'(11);
    end
    for (int i = 16; i < NUM_IRQ; i++) begin
      if (pending_enabled_i[i]) begin
        win_valid = 1'b1;
        win_id    = irq_id_t'(i);
      end
    end
  end

  // M-mode honours mstatus.MIE, U-mode takes anything enabled
  assign take = win_valid &&
                (((priv_lvl_i == PRIV_LVL_M) && mstatus_mie_i) ||
                 (priv_lvl_i == PRIV_LVL_U));

  // ------------------------------
  // Acknowledge
  // ------------------------------
  // One idle cycle after each ack so the strobe never stretches
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
      id_q  <= '0;
    end else begin
      ack_q <= take && !ack_q;
      if (take && !ack_q) begin
        id_q <= win_id;
      end
    end
  end

  assign irq_ack_o = ack_q;
  assign irq_id_o  = id_q;

endmodule : irq_arbiter

/* logic/sleep_ctrl.sv */
/*
 * Sleep controller
 * Counts WFI/WFE residency in writeback and drives core sleep,
 * held off by bus traffic and dropped on any wake source
 */

`timescale 1ns/1ps

module sleep_ctrl import sleep_pkg::*; #(
  parameter int unsigned SLEEP_DELAY = 2
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        wfi_wfe_in_wb_i,
  input  logic        is_wfe_i,
  input  logic [31:0] pending_enabled_i,
  input  logic        debug_req_i,
  input  logic        nmi_i,
  input  logic        wu_wfe_i,
  input  bus_status_t bus_status_i,
  output logic        core_sleep_o
);

  localparam int unsigned CNT_W = $clog2(SLEEP_DELAY + 1);

  logic [CNT_W-1:0] res_cnt_q;
  logic             delay_done;
  logic             blocked;
  logic             wake;
  logic             sleep_q;

  // ------------------------------
  // Residency counter
  // ------------------------------
  // Saturates at the delay, restarts when the instruction leaves
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      res_cnt_q <= '0;
    end else if (!wfi_wfe_in_wb_i) begin
      res_cnt_q <= '0;
    end else if (!delay_done) begin
      res_cnt_q <= res_cnt_q + 1'b1;
    end
  end

  assign delay_done = (res_cnt_q == CNT_W'(SLEEP_DELAY));

  // Outstanding fetches, loads/stores or buffered writes
  assign blocked = bus_status_i.instr_outstanding ||
                   bus_status_i.data_outstanding  ||
                   bus_status_i.wbuf_nonempty;

  // WFE event only counts for WFE
  assign wake = (|pending_enabled_i) || debug_req_i || nmi_i || (wu_wfe_i && is_wfe_i);

  // Sleep is re-qualified every cycle, any failing term drops it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sleep_q <= 1'b0;
    end else begin
      sleep_q <= wfi_wfe_in_wb_i && delay_done && !blocked && !wake;
    end
  end

  assign core_sleep_o = sleep_q;

endmodule : sleep_ctrl

/* logic/irq_sleep_top.sv */
/*
 * Interrupt and sleep controller top
 * Sampler, arbiter, writeback decoder and sleep controller
 */

`timescale 1ns/1ps

module irq_sleep_top import irq_pkg::*; import sleep_pkg::*; #(
  parameter int unsigned SLEEP_DELAY = 2
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Interrupt lines and CSR state
  input  logic [NUM_IRQ-1:0] irq_i,
  input  logic [NUM_IRQ-1:0] mie_i,
  input  logic               mstatus_mie_i,
  input  logic               mstatus_tw_i,
  input  priv_lvl_e          priv_lvl_i,
  // Pipeline status
  input  wb_status_t         wb_status_i,
  input  bus_status_t        bus_status_i,
  // Wake sources
  input  logic               debug_req_i,
  input  logic               nmi_i,
  input  logic               wu_wfe_i,
  output logic [NUM_IRQ-1:0] mip_o,
  output logic               irq_ack_o,
  output irq_id_t            irq_id_o,
  output logic               core_sleep_o
);

  logic [NUM_IRQ-1:0] pending_enabled;
  logic               wfi_wfe_in_wb;
  logic               is_wfe;

  irq_sampler u_irq_sampler (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .irq_i             (irq_i),
    .mie_i             (mie_i),
    .mip_o             (mip_o),
    .pending_enabled_o (pending_enabled)
  );

  irq_arbiter u_irq_arbiter (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .pending_enabled_i (pending_enabled),
    .mstatus_mie_i     (mstatus_mie_i),
    .priv_lvl_i        (priv_lvl_i),
    .irq_ack_o         (irq_ack_o),
    .irq_id_o          (irq_id_o)
  );

  wb_sleep_decoder u_wb_sleep_decoder (
    .wb_status_i     (wb_status_i),
    .priv_lvl_i      (priv_lvl_i),
    .mstatus_tw_i    (mstatus_tw_i),
    .wfi_wfe_in_wb_o (wfi_wfe_in_wb),
    .is_wfe_o        (is_wfe)
  );

  sleep_ctrl #(
    .SLEEP_DELAY (SLEEP_DELAY)
  ) u_sleep_ctrl (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .wfi_wfe_in_wb_i   (wfi_wfe_in_wb),
    .is_wfe_i          (is_wfe),
    .pending_enabled_i (pending_enabled),
    .debug_req_i       (debug_req_i),
    .nmi_i             (nmi_i),
    .wu_wfe_i          (wu_wfe_i),
    .bus_status_i      (bus_status_i),
    .core_sleep_o      (core_sleep_o)
  );

endmodule : irq_sleep_top

/* dv/irq_sleep_tb.sv */
/*
 * Interrupt and sleep controller testbench
 * Random stimulus against a reference model for pending, arbitration and sleep
 */

`timescale 1ns/1ps

module irq_sleep_tb import irq_pkg::*, sleep_pkg::*; ();

  localparam int unsigned SLEEP_DELAY = 2;
  localparam logic [31:0] MODEL_MASK  = 32'hffff_0888;

  logic        clk_i;
  logic        rst_ni;
  logic [31:0] irq_i;
  logic [31:0] mie_i;
  logic        mstatus_mie_i;
  logic        mstatus_tw_i;
  priv_lvl_e   priv_lvl_i;
  wb_status_t  wb_status_i;
  bus_status_t bus_status_i;
  logic        debug_req_i;
  logic        nmi_i;
  logic        wu_wfe_i;
  logic [31:0] mip_o;
  logic        irq_ack_o;
  irq_id_t     irq_id_o;
  logic        core_sleep_o;
  int          errors;
  int          test_base;

  irq_sleep_top dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // ------------------------------
  // Reference model
  // ------------------------------
  function automatic logic [31:0] mask_irq(logic [31:0] lines);
    mask_irq = lines & MODEL_MASK;
  endfunction

  // 31 down to 16, then 11, 3, 7
  function automatic irq_id_t model_winner(logic [31:0] pe);
    logic found;
    found = 1'b0;
    model_winner = '0;
    for (int i = 31; i >= 16; i--) begin
      if (pe[i] && !found) begin
        model_winner = irq_id_t'(i);
        found = 1'b1;
      end
    end
    if (!found) begin
      if (pe[11]) model_winner = 5'd11;
      else if (pe[3]) model_winner = 5'd3;
      else if (pe[7]) model_winner = 5'd7;
    end
  endfunction

  function automatic logic model_take(logic [31:0] pe, logic mie_st, priv_lvl_e priv);
    model_take = (|pe) && ((priv == PRIV_LVL_U) || mie_st);
  endfunction

  function automatic logic instr_valid(wb_status_t wb, priv_lvl_e priv, logic tw);
    logic enc_ok;
    enc_ok = (wb.instr.raw == WFI_INSTR) || (wb.instr.raw == WFE_INSTR);
    instr_valid = enc_ok && wb.valid && !wb.bus_err && wb.mpu_ok && !wb.kill &&
                  !wb.debug_mode && !wb.dcsr_step && !((priv == PRIV_LVL_U) && tw);
  endfunction

  // Uniform pick over the 19 existing lines
  function automatic int random_line();
    int idx;
    idx = $urandom_range(0, 18);
    random_line = (idx < 16) ? 16 + idx : (idx == 16) ? 11 : (idx == 17) ? 3 : 7;
  endfunction

  // ------------------------------
  // Helpers
  // ------------------------------
  task automatic tick();
    @(negedge clk_i);
  endtask

  task automatic flag_mismatch(input string msg);
    $display("CHECK FAILED @%0t ns: %s", $time, msg);
    errors++;
  endtask

  task automatic flag_timeout(input string what);
    $display("Timeout: %s within 20 cycles", what);
    errors++;
  endtask

  task automatic finish_test(input string name);
    $display("%-18s done, %0d errors", name, errors - test_base);
    test_base = errors;
  endtask

  task automatic clear_inputs();
    irq_i = '0;
    mie_i = '0;
    mstatus_mie_i = 1'b0;
    mstatus_tw_i = 1'b0;
    priv_lvl_i = PRIV_LVL_M;
    wb_status_i = '0;
    bus_status_i = '0;
    debug_req_i = 1'b0;
    nmi_i = 1'b0;
    wu_wfe_i = 1'b0;
    repeat (3) tick();
  endtask

  task automatic load_wait_instr(input logic wfe);
    wb_status_i = '0;
    wb_status_i.valid = 1'b1;
    wb_status_i.mpu_ok = 1'b1;
    wb_status_i.instr.raw = wfe ? WFE_INSTR : WFI_INSTR;
  endtask

  // Returns the cycle count at which sleep rose, 0 on timeout
  task automatic wait_for_sleep(output int rise);
    int k;
    k = 0;
    while (k < 20 && !core_sleep_o) begin
      tick();
      k++;
    end
    rise = core_sleep_o ? k : 0;
  endtask

  initial begin : main
    logic [31:0] prev;
    irq_id_t     exp_id;
    logic        prev_ack;
    logic        wfe;
    int          k;
    int          exp_k;
    int          line;
    int          b;

    void'($urandom(32'h679b_6dbc));
    errors = 0;
    test_base = 0;
    rst_ni = 1'b0;
    irq_i = '0;
    mie_i = '0;
    mstatus_mie_i = 1'b0;
    mstatus_tw_i = 1'b0;
    priv_lvl_i = PRIV_LVL_M;
    wb_status_i = '0;
    bus_status_i = '0;
    debug_req_i = 1'b0;
    nmi_i = 1'b0;
    wu_wfe_i = 1'b0;
    repeat (16) tick();
    rst_ni = 1'b1;
    tick();
    if (mip_o !== '0 || irq_ack_o !== 1'b0 || irq_id_o !== '0 || core_sleep_o !== 1'b0)
      flag_mismatch("outputs not zero after reset");

    // Pending word, one cycle behind irq_i
    irq_i = $urandom;
    prev = irq_i;
    for (int i = 0; i < 50; i++) begin
      tick();
      if (mip_o !== mask_irq(prev))
        flag_mismatch($sformatf("mip_o %h, expected %h", mip_o, mask_irq(prev)));
      irq_i = $urandom;
      prev = irq_i;
    end
    finish_test("pending_word");

    // Arbitration with a guaranteed take
    for (int t = 0; t < 40; t++) begin
      clear_inputs();
      line = random_line();
      irq_i = $urandom;
      mie_i = $urandom;
      // Odd settings leave only lines 11, 3 and 7 to compete
      if (t % 2 == 1) begin
        line = 3 + 4 * $urandom_range(0, 2);
        mie_i[31:16] = '0;
      end
      irq_i[line] = 1'b1;
      mie_i[line] = 1'b1;
      priv_lvl_i = $urandom_range(0, 1) ? PRIV_LVL_M : PRIV_LVL_U;
      mstatus_mie_i = (priv_lvl_i == PRIV_LVL_M) ? 1'b1 : 1'($urandom_range(0, 1));
      exp_id = model_winner(mask_irq(irq_i) & mie_i);
      if (!model_take(mask_irq(irq_i) & mie_i, mstatus_mie_i, priv_lvl_i))
        flag_mismatch("generated setting gives no take");
      k = 0;
      while (k < 20 && !irq_ack_o) begin
        tick();
        k++;
      end
      if (!irq_ack_o) begin
        flag_timeout("irq_ack_o did not rise");
      end else begin
        prev_ack = 1'b0;
        repeat (6) begin
          if (prev_ack && irq_ack_o)
            flag_mismatch("irq_ack_o high in two consecutive cycles");
          if (irq_ack_o && irq_id_o !== exp_id)
            flag_mismatch($sformatf("irq_id_o %0d, expected %0d", irq_id_o, exp_id));
          prev_ack = irq_ack_o;
          tick();
        end
      end
    end
    finish_test("arbitration");

    // Settings that must never be taken
    for (int t = 0; t < 20; t++) begin
      clear_inputs();
      priv_lvl_i = $urandom_range(0, 1) ? PRIV_LVL_M : PRIV_LVL_U;
      mstatus_mie_i = 1'b1;
      case ($urandom_range(0, 2))
        0: begin
          priv_lvl_i = PRIV_LVL_M;
          mstatus_mie_i = 1'b0;
          irq_i = $urandom | (32'h1 << random_line());
          mie_i = '1;
        end
        1: begin
          irq_i = $urandom & ~MODEL_MASK;
          mie_i = '1;
        end
        default: begin
          irq_i = $urandom;
          mie_i = ~irq_i;
        end
      endcase
      if (model_take(mask_irq(irq_i) & mie_i, mstatus_mie_i, priv_lvl_i))
        flag_mismatch("generated setting still gives a take");
      repeat (10) begin
        tick();
        if (irq_ack_o !== 1'b0)
          flag_mismatch("irq_ack_o high without a take condition");
      end
    end
    finish_test("no_take");

    // Sleep entry for WFI then WFE, then with traffic outstanding
    for (int w = 0; w < 2; w++) begin
      clear_inputs();
      load_wait_instr(1'(w));
      wait_for_sleep(k);
      if (k == 0)
        flag_timeout("core_sleep_o did not rise");
      else if (k != SLEEP_DELAY + 1)
        flag_mismatch($sformatf("sleep after %0d cycles, expected %0d", k, SLEEP_DELAY + 1));
    end
    for (int t = 0; t < 6; t++) begin
      clear_inputs();
      load_wait_instr(1'($urandom_range(0, 1)));
      bus_status_i = bus_status_t'(3'b001 << $urandom_range(0, 2));
      repeat (10) begin
        tick();
        if (core_sleep_o !== 1'b0)
          flag_mismatch("core_sleep_o high with bus traffic outstanding");
      end
    end
    finish_test("sleep_entry");

    // Wake from sleep by one random source
    for (int t = 0; t < 16; t++) begin
      clear_inputs();
      wfe = 1'($urandom_range(0, 1));
      load_wait_instr(wfe);
      wait_for_sleep(k);
      if (k == 0) begin
        flag_timeout("core_sleep_o did not rise before wake");
      end else begin
        case ($urandom_range(0, 3))
          0: begin
            line = random_line();
            irq_i[line] = 1'b1;
            mie_i[line] = 1'b1;
            exp_k = 2;
          end
          1: begin
            debug_req_i = 1'b1;
            exp_k = 1;
          end
          2: begin
            nmi_i = 1'b1;
            exp_k = 1;
          end
          default: begin
            wu_wfe_i = 1'b1;
            exp_k = wfe ? 1 : 0;
          end
        endcase
        if (exp_k == 0) begin
          repeat (5) begin
            tick();
            if (core_sleep_o !== 1'b1)
              flag_mismatch("WFE event woke a WFI");
          end
        end else begin
          k = 0;
          while (k < 20 && core_sleep_o) begin
            tick();
            k++;
          end
          if (core_sleep_o)
            flag_timeout("core_sleep_o did not fall");
          else if (k != exp_k)
            flag_mismatch($sformatf("woke after %0d cycles, expected %0d", k, exp_k));
        end
      end
    end
    finish_test("wake");

    // WFI spoiled by one random condition
    for (int t = 0; t < 14; t++) begin
      clear_inputs();
      load_wait_instr(1'b0);
      case ($urandom_range(0, 6))
        0: wb_status_i.bus_err = 1'b1;
        1: wb_status_i.kill = 1'b1;
        2: wb_status_i.debug_mode = 1'b1;
        3: wb_status_i.dcsr_step = 1'b1;
        4: wb_status_i.mpu_ok = 1'b0;
        5: begin
          priv_lvl_i = PRIV_LVL_U;
          mstatus_tw_i = 1'b1;
        end
        default: begin
          b = $urandom_range(0, 11);
          wb_status_i.instr.sys.funct12[b] = !wb_status_i.instr.sys.funct12[b];
        end
      endcase
      if (instr_valid(wb_status_i, priv_lvl_i, mstatus_tw_i))
        flag_mismatch("generated instruction is still valid");
      repeat (10) begin
        tick();
        if (core_sleep_o !== 1'b0)
          flag_mismatch("core_sleep_o high for an invalidated WFI");
      end
    end
    finish_test("invalidated");

    $display("6 tests run, %0d errors", errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule : irq_sleep_tb

/* all.f */
logic/irq_pkg.sv
logic/sleep_pkg.sv
logic/irq_sampler.sv
logic/wb_sleep_decoder.sv
logic/irq_arbiter.sv
logic/sleep_ctrl.sv
logic/irq_sleep_top.sv
dv/irq_sleep_tb.sv

/* Bender.yml */
package:
  name: irq_sleep

sources:
  - logic/irq_pkg.sv
  - logic/sleep_pkg.sv
  - logic/irq_sampler.sv
  - logic/wb_sleep_decoder.sv
  - logic/irq_arbiter.sv
  - logic/sleep_ctrl.sv
  - logic/irq_sleep_top.sv
  - target: test
    files:
      - dv/irq_sleep_tb.sv
